//--- include/alloc_settings.svh
// Widths below are shared by every block; the free-list depth must be a power of two
`ifndef ALLOC_SETTINGS_SVH
`define ALLOC_SETTINGS_SVH

// Slots renamed per cycle
`define ALLOC_SLOTS 4

// Physical and architectural register number widths
`define ALLOC_PREG_W 6
`define ALLOC_AREG_W 5

// Reorder-buffer index without the wrap bit
`define ALLOC_ROB_W 6

// Free registers held at reset, numbered from this value upward
`define ALLOC_FL_DEPTH 32

`define ALLOC_PC_W 32

`endif

//--- source/alloc_inst_pkg.sv
// Slot layouts between decode, allocation and scheduler; field order is fixed by the pipeline
`default_nettype none

`include "alloc_settings.svh"

package alloc_inst_pkg;

   // Slot as handed over by decode
   typedef struct packed {
      logic                      valid;
      logic                      writes_reg;
      logic                      is_load;
      logic                      is_store;
      logic                      is_branch;
      logic                      pred_taken;
      logic [`ALLOC_AREG_W-1:0]  dest_areg;
      logic [`ALLOC_PC_W-1:0]    pc;
   } id_slot_t;

   // Renamed slot for the scheduler, rob_idx keeps its wrap bit
   typedef struct packed {
      logic                      valid;
      logic [`ALLOC_PREG_W-1:0]  dest_preg;
      logic [`ALLOC_ROB_W:0]     rob_idx;
      logic                      is_load;
      logic                      is_store;
      logic                      is_branch;
      logic [`ALLOC_PC_W-1:0]    pc;
   } sch_slot_t;

   // One bit per slot, bit 0 is the oldest slot
   typedef logic [`ALLOC_SLOTS-1:0] slot_mask_t;

endpackage

`default_nettype wire

//--- source/alloc_rob_pkg.sv
// Index and pointer types; pointers carry one extra wrap bit above the entry index
`default_nettype none

`include "alloc_settings.svh"

package alloc_rob_pkg;

   typedef logic [`ALLOC_PREG_W-1:0] preg_t;

   // Reorder-buffer index plus wrap bit
   typedef logic [`ALLOC_ROB_W:0] rob_idx_t;

   // Free-list position plus wrap bit
   typedef logic [$clog2(`ALLOC_FL_DEPTH):0] fl_ptr_t;

   // One byte per slot of a load or store list
   typedef struct packed {
      logic     valid;
      rob_idx_t idx;
   } lsq_entry_t;

   typedef lsq_entry_t [`ALLOC_SLOTS-1:0] lsq_list_t;

endpackage

`default_nettype wire

//--- source/inst_checker.sv
// Classifies the four decoded slots; every mask is already gated by fire, which holds decode
`timescale 1ns/1ns
`default_nettype none

`include "alloc_settings.svh"

module inst_checker
   import alloc_inst_pkg::*;
(
   input  id_slot_t   inst0,
   input  id_slot_t   inst1,
   input  id_slot_t   inst2,
   input  id_slot_t   inst3,
   input  logic       stall,
   input  logic       full,
   input  logic       no_free_preg,
   output slot_mask_t need_mask,
   output slot_mask_t ld_mask,
   output slot_mask_t st_mask,
   output slot_mask_t brch_mask,
   output slot_mask_t pred_mask,
   output logic       fire,
   output logic       all_nop
);

   id_slot_t   slot [`ALLOC_SLOTS];
   slot_mask_t valid_mask;

   assign slot[0] = inst0;
   assign slot[1] = inst1;
   assign slot[2] = inst2;
   assign slot[3] = inst3;

   // Whole group moves or none of it does
   assign fire = !stall && !full && !no_free_preg;

   always_comb begin
      for (int i = 0; i < `ALLOC_SLOTS; i++) begin
         valid_mask[i] = fire && slot[i].valid;

         // r0 is never renamed
         need_mask[i] = valid_mask[i] && slot[i].writes_reg &&
                        (slot[i].dest_areg != '0);

         ld_mask[i]   = valid_mask[i] && slot[i].is_load;
         st_mask[i]   = valid_mask[i] && slot[i].is_store;
         brch_mask[i] = valid_mask[i] && slot[i].is_branch;
         pred_mask[i] = valid_mask[i] && slot[i].is_branch && slot[i].pred_taken;
      end
   end

   // Nothing reaches commit this cycle
   assign all_nop = !(|valid_mask);

endmodule

`default_nettype wire

//--- source/branch_unit.sv
// One checkpoint per reorder index; a misprediction flushes every checkpoint, not only younger ones
`timescale 1ns/1ns
`default_nettype none

`include "alloc_settings.svh"

module branch_unit
   import alloc_inst_pkg::*, alloc_rob_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  slot_mask_t              brch_mask,
   input  slot_mask_t              need_mask,
   input  rob_idx_t                inst_rob_base,
   input  fl_ptr_t                 alloc_head,
   input  logic                    mis_pred,
   input  logic [`ALLOC_ROB_W-1:0] mis_pred_indx,
   input  logic                    cmt_brch,
   input  logic [`ALLOC_ROB_W-1:0] cmt_brch_indx,
   output logic                    flush,
   output fl_ptr_t                 flush_pos
);

   localparam int ENTRIES = 1 << `ALLOC_ROB_W;

   fl_ptr_t                 ckpt_pos [ENTRIES];
   logic [ENTRIES-1:0]      ckpt_vld;

   fl_ptr_t                 new_pos [`ALLOC_SLOTS];
   logic [`ALLOC_ROB_W-1:0] br_idx  [`ALLOC_SLOTS];
   logic [$clog2(`ALLOC_SLOTS):0] later_cnt;

   // Walk down from the youngest slot, backing off the registers taken after each one
   always_comb begin
      later_cnt = '0;
      for (int i = `ALLOC_SLOTS - 1; i >= 0; i--) begin
         new_pos[i] = alloc_head - fl_ptr_t'(later_cnt);
         br_idx[i]  = inst_rob_base[`ALLOC_ROB_W-1:0] + (`ALLOC_ROB_W)'(i);
         later_cnt  = later_cnt + need_mask[i];
      end
   end

   assign flush     = mis_pred && ckpt_vld[mis_pred_indx];
   assign flush_pos = ckpt_pos[mis_pred_indx];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ckpt_vld <= '0;
      end else if (flush) begin
         ckpt_vld <= '0;
      end else begin
         if (cmt_brch)
            ckpt_vld[cmt_brch_indx] <= 1'b0;
         // A new branch may reuse the index just committed
         for (int i = 0; i < `ALLOC_SLOTS; i++) begin
            if (brch_mask[i])
               ckpt_vld[br_idx[i]] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < `ALLOC_SLOTS; i++) begin
         if (brch_mask[i])
            ckpt_pos[br_idx[i]] <= new_pos[i];
      end
   end

endmodule

`default_nettype wire

//--- source/free_list.sv
// Circular free list; commit must never return more registers than are currently allocated
`timescale 1ns/1ns
`default_nettype none

`include "alloc_settings.svh"

module free_list
   import alloc_inst_pkg::*, alloc_rob_pkg::*;
(
   input  logic                          clk,
   input  logic                          rst_n,
   input  slot_mask_t                    need_mask,
   input  logic                          fire,
   input  preg_t                         ret_preg0,
   input  preg_t                         ret_preg1,
   input  preg_t                         ret_preg2,
   input  preg_t                         ret_preg3,
   input  logic [$clog2(`ALLOC_SLOTS):0] ret_num,
   input  logic                          flush,
   input  fl_ptr_t                       flush_pos,
   output preg_t                         preg_out0,
   output preg_t                         preg_out1,
   output preg_t                         preg_out2,
   output preg_t                         preg_out3,
   output fl_ptr_t                       alloc_head,
   output logic                          no_free_preg
);

   localparam int IDX_W = $clog2(`ALLOC_FL_DEPTH);
   localparam int CNT_W = $clog2(`ALLOC_SLOTS) + 1;

   preg_t      fl_mem [`ALLOC_FL_DEPTH];
   fl_ptr_t    head;
   fl_ptr_t    tail;
   fl_ptr_t    tail_nxt;
   logic [IDX_W:0] count;

   preg_t      ret_preg [`ALLOC_SLOTS];
   preg_t      pout     [`ALLOC_SLOTS];
   fl_ptr_t    rd_ptr   [`ALLOC_SLOTS];
   fl_ptr_t    wr_ptr   [`ALLOC_SLOTS];
   logic [CNT_W-1:0] alloc_num;
   logic [CNT_W-1:0] alloc_cnt;

   assign ret_preg[0] = ret_preg0;
   assign ret_preg[1] = ret_preg1;
   assign ret_preg[2] = ret_preg2;
   assign ret_preg[3] = ret_preg3;

   // Slot offset is the number of requesting slots below it
   always_comb begin
      alloc_num = '0;
      for (int i = 0; i < `ALLOC_SLOTS; i++) begin
         rd_ptr[i] = head + fl_ptr_t'(alloc_num);
         wr_ptr[i] = tail + fl_ptr_t'(i);
         pout[i]   = need_mask[i] ? fl_mem[rd_ptr[i][IDX_W-1:0]] : '0;
         alloc_num = alloc_num + need_mask[i];
      end
   end

   assign preg_out0 = pout[0];
   assign preg_out1 = pout[1];
   assign preg_out2 = pout[2];
   assign preg_out3 = pout[3];

   assign alloc_cnt    = fire ? alloc_num : '0;
   assign alloc_head   = head + fl_ptr_t'(alloc_cnt);
   assign tail_nxt     = tail + fl_ptr_t'(ret_num);
   assign no_free_preg = count < (IDX_W + 1)'(`ALLOC_SLOTS);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         head  <= '0;
         // Wrap bit set, so the list starts full
         tail  <= fl_ptr_t'(`ALLOC_FL_DEPTH);
         count <= (IDX_W + 1)'(`ALLOC_FL_DEPTH);
      end else begin
         tail <= tail_nxt;
         if (flush) begin
            head  <= flush_pos;
            count <= tail_nxt - flush_pos;
         end else begin
            head  <= alloc_head;
            count <= count + (IDX_W + 1)'(ret_num) - (IDX_W + 1)'(alloc_cnt);
         end
      end
   end

   // Registers above the architectural set are free after reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `ALLOC_FL_DEPTH; i++)
            fl_mem[i] <= preg_t'(`ALLOC_FL_DEPTH + i);
      end else begin
         for (int i = 0; i < `ALLOC_SLOTS; i++) begin
            if (i < ret_num)
               fl_mem[wr_ptr[i][IDX_W-1:0]] <= ret_preg[i];
         end
      end
   end

endmodule

`default_nettype wire

//--- source/inst_combiner.sv
// Builds scheduler slots and load/store lists; invalid slots and non-fire cycles come out as zero
`timescale 1ns/1ns
`default_nettype none

`include "alloc_settings.svh"

module inst_combiner
   import alloc_inst_pkg::*, alloc_rob_pkg::*;
(
   input  id_slot_t   inst0,
   input  id_slot_t   inst1,
   input  id_slot_t   inst2,
   input  id_slot_t   inst3,
   input  preg_t      preg_in0,
   input  preg_t      preg_in1,
   input  preg_t      preg_in2,
   input  preg_t      preg_in3,
   input  slot_mask_t need_mask,
   input  slot_mask_t ld_mask,
   input  slot_mask_t st_mask,
   input  slot_mask_t brch_mask,
   input  logic       fire,
   input  rob_idx_t   nxt_indx,
   output sch_slot_t  slot_out0,
   output sch_slot_t  slot_out1,
   output sch_slot_t  slot_out2,
   output sch_slot_t  slot_out3,
   output lsq_list_t  ld_indx,
   output lsq_list_t  st_indx,
   output rob_idx_t   rob_base
);

   id_slot_t  inst    [`ALLOC_SLOTS];
   preg_t     preg    [`ALLOC_SLOTS];
   sch_slot_t slot    [`ALLOC_SLOTS];
   rob_idx_t  rob_idx [`ALLOC_SLOTS];

   assign inst[0] = inst0;
   assign inst[1] = inst1;
   assign inst[2] = inst2;
   assign inst[3] = inst3;
   assign preg[0] = preg_in0;
   assign preg[1] = preg_in1;
   assign preg[2] = preg_in2;
   assign preg[3] = preg_in3;

   // Slot 0 takes the commit stage's next index
   assign rob_base = nxt_indx;

   always_comb begin
      for (int i = 0; i < `ALLOC_SLOTS; i++) begin
         // Wrap bit flips naturally on overflow
         rob_idx[i] = nxt_indx + rob_idx_t'(i);

         slot[i] = '0;
         if (fire && inst[i].valid) begin
            slot[i].valid     = 1'b1;
            slot[i].dest_preg = need_mask[i] ? preg[i] : '0;
            slot[i].rob_idx   = rob_idx[i];
            slot[i].is_load   = ld_mask[i];
            slot[i].is_store  = st_mask[i];
            slot[i].is_branch = brch_mask[i];
            slot[i].pc        = inst[i].pc;
         end

         ld_indx[i] = '0;
         if (ld_mask[i])
            ld_indx[i] = '{valid: 1'b1, idx: rob_idx[i]};
         st_indx[i] = '0;
         if (st_mask[i])
            st_indx[i] = '{valid: 1'b1, idx: rob_idx[i]};
      end
   end

   assign slot_out0 = slot[0];
   assign slot_out1 = slot[1];
   assign slot_out2 = slot[2];
   assign slot_out3 = slot[3];

endmodule

`default_nettype wire

//--- source/alloc_stage.sv
// Combinational rename stage; decode must hold its slots while all_nop_to_cmt is high
`timescale 1ns/1ns
`default_nettype none

`include "alloc_settings.svh"

module alloc_stage
   import alloc_inst_pkg::*, alloc_rob_pkg::*;
(
   input  logic                          clk,
   input  logic                          rst_n,
   input  id_slot_t                      inst_from_id0,
   input  id_slot_t                      inst_from_id1,
   input  id_slot_t                      inst_from_id2,
   input  id_slot_t                      inst_from_id3,
   input  rob_idx_t                      nxt_indx_from_cmt,
   input  preg_t                         free_pr_from_cmt0,
   input  preg_t                         free_pr_from_cmt1,
   input  preg_t                         free_pr_from_cmt2,
   input  preg_t                         free_pr_from_cmt3,
   input  logic [$clog2(`ALLOC_SLOTS):0] free_pr_num_from_cmt,
   input  logic                          mis_pred_from_cmt,
   input  logic [`ALLOC_ROB_W-1:0]       mis_pred_indx_from_cmt,
   input  logic                          cmt_brch_from_cmt,
   input  logic [`ALLOC_ROB_W-1:0]       cmt_brch_indx_from_cmt,
   input  logic                          stall,
   input  logic                          full_from_sch,
   output sch_slot_t                     inst_out_to_sch0,
   output sch_slot_t                     inst_out_to_sch1,
   output sch_slot_t                     inst_out_to_sch2,
   output sch_slot_t                     inst_out_to_sch3,
   output lsq_list_t                     ld_indx_to_wb,
   output lsq_list_t                     st_indx_to_wb,
   output slot_mask_t                    reg_wrt_to_cmt,
   output slot_mask_t                    ld_en_to_cmt,
   output slot_mask_t                    st_en_to_cmt,
   output slot_mask_t                    brch_to_cmt,
   output slot_mask_t                    pred_res_to_cmt,
   output logic                          all_nop_to_cmt,
   output logic                          no_free_preg_to_if
);

   logic    fire;
   logic    flush;
   fl_ptr_t flush_pos;
   fl_ptr_t alloc_head;
   rob_idx_t rob_base;
   preg_t   preg0, preg1, preg2, preg3;

   inst_checker inst_checker_i (
      .inst0        (inst_from_id0),
      .inst1        (inst_from_id1),
      .inst2        (inst_from_id2),
      .inst3        (inst_from_id3),
      .stall        (stall),
      .full         (full_from_sch),
      .no_free_preg (no_free_preg_to_if),
      .need_mask    (reg_wrt_to_cmt),
      .ld_mask      (ld_en_to_cmt),
      .st_mask      (st_en_to_cmt),
      .brch_mask    (brch_to_cmt),
      .pred_mask    (pred_res_to_cmt),
      .fire         (fire),
      .all_nop      (all_nop_to_cmt)
   );

   free_list free_list_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .need_mask    (reg_wrt_to_cmt),
      .fire         (fire),
      .ret_preg0    (free_pr_from_cmt0),
      .ret_preg1    (free_pr_from_cmt1),
      .ret_preg2    (free_pr_from_cmt2),
      .ret_preg3    (free_pr_from_cmt3),
      .ret_num      (free_pr_num_from_cmt),
      .flush        (flush),
      .flush_pos    (flush_pos),
      .preg_out0    (preg0),
      .preg_out1    (preg1),
      .preg_out2    (preg2),
      .preg_out3    (preg3),
      .alloc_head   (alloc_head),
      .no_free_preg (no_free_preg_to_if)
   );

   branch_unit branch_unit_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .brch_mask     (brch_to_cmt),
      .need_mask     (reg_wrt_to_cmt),
      .inst_rob_base (rob_base),
      .alloc_head    (alloc_head),
      .mis_pred      (mis_pred_from_cmt),
      .mis_pred_indx (mis_pred_indx_from_cmt),
      .cmt_brch      (cmt_brch_from_cmt),
      .cmt_brch_indx (cmt_brch_indx_from_cmt),
      .flush         (flush),
      .flush_pos     (flush_pos)
   );

   inst_combiner inst_combiner_i (
      .inst0     (inst_from_id0),
      .inst1     (inst_from_id1),
      .inst2     (inst_from_id2),
      .inst3     (inst_from_id3),
      .preg_in0  (preg0),
      .preg_in1  (preg1),
      .preg_in2  (preg2),
      .preg_in3  (preg3),
      .need_mask (reg_wrt_to_cmt),
      .ld_mask   (ld_en_to_cmt),
      .st_mask   (st_en_to_cmt),
      .brch_mask (brch_to_cmt),
      .fire      (fire),
      .nxt_indx  (nxt_indx_from_cmt),
      .slot_out0 (inst_out_to_sch0),
      .slot_out1 (inst_out_to_sch1),
      .slot_out2 (inst_out_to_sch2),
      .slot_out3 (inst_out_to_sch3),
      .ld_indx   (ld_indx_to_wb),
      .st_indx   (st_indx_to_wb),
      .rob_base  (rob_base)
   );

endmodule

`default_nettype wire

//--- verif/alloc_stage_chk.sv
// Bound into alloc_stage; every property is skipped while rst_n is low
`timescale 1ns/1ns
`default_nettype none

module alloc_stage_chk
   import alloc_inst_pkg::*, alloc_rob_pkg::*;
(
   input logic       clk,
   input logic       rst_n,
   input logic       stall,
   input logic       full,
   input logic       flush,
   input fl_ptr_t    flush_pos,
   input fl_ptr_t    alloc_head,
   input sch_slot_t  slot0,
   input sch_slot_t  slot1,
   input sch_slot_t  slot2,
   input sch_slot_t  slot3,
   input slot_mask_t need_mask,
   input logic       no_free_preg
);

   // Held stage sends nothing to the scheduler
   hold_is_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      (stall || full || no_free_preg) |->
         (slot0 == '0 && slot1 == '0 && slot2 == '0 && slot3 == '0))
      else $error("Scheduler slot is not zero while the stage is held");

   // Head before allocation must not move while the list is short
   empty_blocks_alloc: assert property (@(posedge clk) disable iff (!rst_n)
      no_free_preg && !flush |=>
         alloc_head - fl_ptr_t'($countones(need_mask)) ==
         $past(alloc_head - fl_ptr_t'($countones(need_mask))))
      else $error("Register allocated while the free list is short");

   // alloc_head is the head plus this cycle's allocations
   flush_moves_head: assert property (@(posedge clk) disable iff (!rst_n)
      flush |=> alloc_head == $past(flush_pos) + fl_ptr_t'($countones(need_mask)))
      else $error("Free-list head did not return to the checkpoint after a flush");

endmodule

bind alloc_stage alloc_stage_chk alloc_stage_chk_i (
   .clk          (clk),
   .rst_n        (rst_n),
   .stall        (stall),
   .full         (full_from_sch),
   .flush        (flush),
   .flush_pos    (flush_pos),
   .alloc_head   (alloc_head),
   .slot0        (inst_out_to_sch0),
   .slot1        (inst_out_to_sch1),
   .slot2        (inst_out_to_sch2),
   .slot3        (inst_out_to_sch3),
   .need_mask    (reg_wrt_to_cmt),
   .no_free_preg (no_free_preg_to_if)
);

`default_nettype wire

//--- verif/alloc_stage_tb.sv
// Reference model assumes commit only returns registers that are allocated and never wraps the list
`timescale 1ns/1ns
`default_nettype none

`include "alloc_settings.svh"

module alloc_stage_tb
   import alloc_inst_pkg::*, alloc_rob_pkg::*;
();

   logic       clk = 1'b0;
   logic       rst_n;
   id_slot_t   inst_from_id0, inst_from_id1, inst_from_id2, inst_from_id3;
   rob_idx_t   nxt_indx_from_cmt;
   preg_t      free_pr_from_cmt0, free_pr_from_cmt1, free_pr_from_cmt2, free_pr_from_cmt3;
   logic [2:0] free_pr_num_from_cmt;
   logic       mis_pred_from_cmt;
   logic [5:0] mis_pred_indx_from_cmt;
   logic       cmt_brch_from_cmt;
   logic [5:0] cmt_brch_indx_from_cmt;
   logic       stall;
   logic       full_from_sch;
   sch_slot_t  inst_out_to_sch0, inst_out_to_sch1, inst_out_to_sch2, inst_out_to_sch3;
   lsq_list_t  ld_indx_to_wb, st_indx_to_wb;
   slot_mask_t reg_wrt_to_cmt, ld_en_to_cmt, st_en_to_cmt, brch_to_cmt, pred_res_to_cmt;
   logic       all_nop_to_cmt;
   logic       no_free_preg_to_if;

   // Stimulus for the next cycle, set by the tests
   id_slot_t   grp [4];
   rob_idx_t   nxt_v;
   logic       stall_v, full_v;
   preg_t      ret_v [4];
   int         ret_n;
   logic       mp_v, cb_v;
   logic [5:0] mp_idx, cb_idx;

   // Reference model
   preg_t       fl_q [$];
   preg_t       hist [$];
   int          ckpt_pos [64];
   logic [63:0] ckpt_vld;

   logic [31:0] lfsr = 32'h0396_5e25;
   int          val_errs = 0;
   int          other_errs = 0;

   alloc_stage alloc_stage_i (
      .clk (clk), .rst_n (rst_n),
      .inst_from_id0 (inst_from_id0), .inst_from_id1 (inst_from_id1),
      .inst_from_id2 (inst_from_id2), .inst_from_id3 (inst_from_id3),
      .nxt_indx_from_cmt (nxt_indx_from_cmt),
      .free_pr_from_cmt0 (free_pr_from_cmt0), .free_pr_from_cmt1 (free_pr_from_cmt1),
      .free_pr_from_cmt2 (free_pr_from_cmt2), .free_pr_from_cmt3 (free_pr_from_cmt3),
      .free_pr_num_from_cmt (free_pr_num_from_cmt),
      .mis_pred_from_cmt (mis_pred_from_cmt), .mis_pred_indx_from_cmt (mis_pred_indx_from_cmt),
      .cmt_brch_from_cmt (cmt_brch_from_cmt), .cmt_brch_indx_from_cmt (cmt_brch_indx_from_cmt),
      .stall (stall), .full_from_sch (full_from_sch),
      .inst_out_to_sch0 (inst_out_to_sch0), .inst_out_to_sch1 (inst_out_to_sch1),
      .inst_out_to_sch2 (inst_out_to_sch2), .inst_out_to_sch3 (inst_out_to_sch3),
      .ld_indx_to_wb (ld_indx_to_wb), .st_indx_to_wb (st_indx_to_wb),
      .reg_wrt_to_cmt (reg_wrt_to_cmt), .ld_en_to_cmt (ld_en_to_cmt),
      .st_en_to_cmt (st_en_to_cmt), .brch_to_cmt (brch_to_cmt),
      .pred_res_to_cmt (pred_res_to_cmt), .all_nop_to_cmt (all_nop_to_cmt),
      .no_free_preg_to_if (no_free_preg_to_if)
   );

   always #10 clk = ~clk;

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        b;
      r = '0;
      for (int j = 0; j < n; j++) begin
         b    = lfsr[0];
         lfsr = lfsr >> 1;
         if (b)
            lfsr = lfsr ^ 32'h8020_0003;
         r = {r[30:0], b};
      end
      return r;
   endfunction

   function automatic id_slot_t build_slot(input logic wr, input logic ld, input logic st,
                                           input logic br, input logic [4:0] areg,
                                           input logic [31:0] pc);
      id_slot_t s;
      s = '{valid: 1'b1, writes_reg: wr, is_load: ld, is_store: st, is_branch: br,
            pred_taken: br, dest_areg: areg, pc: pc};
      return s;
   endfunction

   function automatic id_slot_t rand_slot(input logic [31:0] pc);
      id_slot_t   s;
      logic [1:0] kind;
      s          = '0;
      s.pc       = pc;
      s.valid    = 1'(rand_bits(1));
      // 0 alu, 1 load, 2 store, 3 branch
      kind       = 2'(rand_bits(2));
      s.is_load  = (kind == 2'd1);
      s.is_store = (kind == 2'd2);
      s.is_branch = (kind == 2'd3);
      if (kind < 2'd2)
         s.writes_reg = 1'(rand_bits(1));
      if (s.is_branch)
         s.pred_taken = 1'(rand_bits(1));
      if (2'(rand_bits(2)) != 2'd0)
         s.dest_areg = 5'(rand_bits(5));
      return s;
   endfunction

   task automatic check_slot(input string name, input sch_slot_t got, input sch_slot_t exp);
      if (got !== exp) begin
         val_errs++;
         $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
      end
   endtask

   task automatic check_preg(input string name, input preg_t got, input preg_t exp);
      if (got !== exp) begin
         val_errs++;
         $display("ERR %0t %s got %0d exp %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_mask(input string name, input slot_mask_t got, input slot_mask_t exp);
      if (got !== exp) begin
         val_errs++;
         $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
      end
   endtask

   task automatic check_lsq(input string name, input lsq_list_t got, input lsq_list_t exp);
      if (got !== exp) begin
         val_errs++;
         $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input bit got, input bit exp);
      if (got !== exp) begin
         val_errs++;
         $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
      end
   endtask

   task automatic drive_idle();
      inst_from_id0 <= '0;
      inst_from_id1 <= '0;
      inst_from_id2 <= '0;
      inst_from_id3 <= '0;
      nxt_indx_from_cmt <= '0;
      free_pr_from_cmt0 <= '0;
      free_pr_from_cmt1 <= '0;
      free_pr_from_cmt2 <= '0;
      free_pr_from_cmt3 <= '0;
      free_pr_num_from_cmt <= '0;
      mis_pred_from_cmt <= 1'b0;
      mis_pred_indx_from_cmt <= '0;
      cmt_brch_from_cmt <= 1'b0;
      cmt_brch_indx_from_cmt <= '0;
      stall <= 1'b0;
      full_from_sch <= 1'b0;
   endtask

   task automatic apply_reset();
      @(posedge clk);
      rst_n <= 1'b0;
      drive_idle();
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      fl_q.delete();
      hist.delete();
      for (int i = 0; i < `ALLOC_FL_DEPTH; i++)
         fl_q.push_back(preg_t'(`ALLOC_FL_DEPTH + i));
      ckpt_vld = '0;
      stall_v = 1'b0;
      full_v = 1'b0;
      ret_n = 0;
      mp_v = 1'b0;
      cb_v = 1'b0;
   endtask

   // One cycle: drive on the rising edge, check at the falling edge, then advance the model
   task automatic drive_and_check();
      sch_slot_t  exp_slot [4];
      lsq_list_t  exp_ld, exp_st;
      slot_mask_t exp_need, exp_ldm, exp_stm, exp_br, exp_pred;
      logic       exp_fire, exp_nofree, any_valid;
      int         br_pos [4];
      logic       br_on [4];
      int         k;
      rob_idx_t   idx;
      @(posedge clk);
      inst_from_id0 <= grp[0];
      inst_from_id1 <= grp[1];
      inst_from_id2 <= grp[2];
      inst_from_id3 <= grp[3];
      nxt_indx_from_cmt <= nxt_v;
      free_pr_from_cmt0 <= ret_v[0];
      free_pr_from_cmt1 <= ret_v[1];
      free_pr_from_cmt2 <= ret_v[2];
      free_pr_from_cmt3 <= ret_v[3];
      free_pr_num_from_cmt <= 3'(ret_n);
      mis_pred_from_cmt <= mp_v;
      mis_pred_indx_from_cmt <= mp_idx;
      cmt_brch_from_cmt <= cb_v;
      cmt_brch_indx_from_cmt <= cb_idx;
      stall <= stall_v;
      full_from_sch <= full_v;
      @(negedge clk);

      exp_nofree = fl_q.size() < 4;
      exp_fire = !stall_v && !full_v && !exp_nofree;
      {exp_need, exp_ldm, exp_stm, exp_br, exp_pred} = '0;
      exp_ld = '0;
      exp_st = '0;
      any_valid = 1'b0;
      k = 0;
      for (int i = 0; i < 4; i++) begin
         exp_slot[i] = '0;
         br_on[i] = 1'b0;
         br_pos[i] = 0;
         idx = nxt_v + rob_idx_t'(i);
         if (exp_fire && grp[i].valid) begin
            any_valid = 1'b1;
            exp_need[i] = grp[i].writes_reg && (grp[i].dest_areg != '0);
            exp_ldm[i] = grp[i].is_load;
            exp_stm[i] = grp[i].is_store;
            exp_br[i] = grp[i].is_branch;
            exp_pred[i] = grp[i].is_branch && grp[i].pred_taken;
            exp_slot[i] = '{valid: 1'b1, dest_preg: '0, rob_idx: idx, is_load: exp_ldm[i],
                            is_store: exp_stm[i], is_branch: exp_br[i], pc: grp[i].pc};
            if (exp_need[i]) begin
               exp_slot[i].dest_preg = fl_q[k];
               k++;
            end
            if (exp_ldm[i])
               exp_ld[i] = '{valid: 1'b1, idx: idx};
            if (exp_stm[i])
               exp_st[i] = '{valid: 1'b1, idx: idx};
            // Checkpoint sits just past this slot's own allocation
            br_on[i] = exp_br[i];
            br_pos[i] = hist.size() + k;
         end
      end

      check_slot("inst_out_to_sch0", inst_out_to_sch0, exp_slot[0]);
      check_slot("inst_out_to_sch1", inst_out_to_sch1, exp_slot[1]);
      check_slot("inst_out_to_sch2", inst_out_to_sch2, exp_slot[2]);
      check_slot("inst_out_to_sch3", inst_out_to_sch3, exp_slot[3]);
      check_lsq("ld_indx_to_wb", ld_indx_to_wb, exp_ld);
      check_lsq("st_indx_to_wb", st_indx_to_wb, exp_st);
      check_mask("reg_wrt_to_cmt", reg_wrt_to_cmt, exp_need);
      check_mask("ld_en_to_cmt", ld_en_to_cmt, exp_ldm);
      check_mask("st_en_to_cmt", st_en_to_cmt, exp_stm);
      check_mask("brch_to_cmt", brch_to_cmt, exp_br);
      check_mask("pred_res_to_cmt", pred_res_to_cmt, exp_pred);
      check_flag("all_nop_to_cmt", all_nop_to_cmt, !any_valid);
      check_flag("no_free_preg_to_if", no_free_preg_to_if, exp_nofree);

      // Model state after the coming edge
      if (mp_v && ckpt_vld[mp_idx]) begin
         while (hist.size() > ckpt_pos[mp_idx])
            fl_q.push_front(hist.pop_back());
         ckpt_vld = '0;
      end else begin
         repeat (k) hist.push_back(fl_q.pop_front());
         if (cb_v)
            ckpt_vld[cb_idx] = 1'b0;
         for (int i = 0; i < 4; i++) begin
            idx = nxt_v + rob_idx_t'(i);
            if (br_on[i]) begin
               ckpt_vld[idx[5:0]] = 1'b1;
               ckpt_pos[idx[5:0]] = br_pos[i];
            end
         end
      end
      for (int j = 0; j < ret_n; j++)
         fl_q.push_back(ret_v[j]);

      ret_n = 0;
      mp_v = 1'b0;
      cb_v = 1'b0;
   endtask

   task automatic set_writers(input int first_areg);
      for (int i = 0; i < 4; i++)
         grp[i] = build_slot(1'b1, 1'b0, 1'b0, 1'b0, 5'(first_areg + i), 32'h100 + 32'(4 * i));
   endtask

   task automatic test_first_group();
      apply_reset();
      set_writers(1);
      nxt_v = 7'd5;
      drive_and_check();
      check_preg("inst_out_to_sch0.dest_preg", inst_out_to_sch0.dest_preg, 6'd32);
      check_preg("inst_out_to_sch1.dest_preg", inst_out_to_sch1.dest_preg, 6'd33);
      check_preg("inst_out_to_sch2.dest_preg", inst_out_to_sch2.dest_preg, 6'd34);
      check_preg("inst_out_to_sch3.dest_preg", inst_out_to_sch3.dest_preg, 6'd35);
   endtask

   task automatic test_random_groups();
      apply_reset();
      for (int c = 0; c < 6; c++) begin
         for (int i = 0; i < 4; i++)
            grp[i] = rand_slot(32'h2000 + 32'(16 * c + 4 * i));
         nxt_v = 7'(rand_bits(7));
         drive_and_check();
      end
   endtask

   task automatic test_hold();
      apply_reset();
      set_writers(3);
      nxt_v = 7'd60;
      stall_v = 1'b1;
      drive_and_check();
      stall_v = 1'b0;
      full_v = 1'b1;
      drive_and_check();
      full_v = 1'b0;
      drive_and_check();
      check_preg("inst_out_to_sch0.dest_preg", inst_out_to_sch0.dest_preg, 6'd32);
   endtask

   task automatic test_exhaust();
      int n;
      apply_reset();
      set_writers(1);
      // Slot 3 does not write, so three registers go per cycle
      grp[3].writes_reg = 1'b0;
      nxt_v = 7'd20;
      n = 0;
      while (!no_free_preg_to_if && n < 16) begin
         drive_and_check();
         n++;
      end
      if (!no_free_preg_to_if) begin
         other_errs++;
         $display("Timeout: the free list never ran short of registers");
      end
      ret_v = '{6'd45, 6'd33, 6'd50, 6'd0};
      ret_n = 3;
      stall_v = 1'b1;
      drive_and_check();
      n = 0;
      while (no_free_preg_to_if && n < 4) begin
         drive_and_check();
         n++;
      end
      if (no_free_preg_to_if) begin
         other_errs++;
         $display("Timeout: returned registers did not clear the empty flag");
      end
      stall_v = 1'b0;
      set_writers(1);
      drive_and_check();
      check_preg("inst_out_to_sch2.dest_preg", inst_out_to_sch2.dest_preg, 6'd45);
      check_preg("inst_out_to_sch3.dest_preg", inst_out_to_sch3.dest_preg, 6'd33);
   endtask

   task automatic test_branch_recovery(input logic commit_first);
      apply_reset();
      set_writers(1);
      grp[1] = build_slot(1'b0, 1'b0, 1'b0, 1'b1, 5'd0, 32'h104);
      nxt_v = 7'd10;
      drive_and_check();
      set_writers(5);
      nxt_v = 7'd14;
      drive_and_check();
      stall_v = 1'b1;
      if (commit_first) begin
         cb_v = 1'b1;
         cb_idx = 6'd11;
         drive_and_check();
      end
      mp_v = 1'b1;
      mp_idx = 6'd11;
      drive_and_check();
      stall_v = 1'b0;
      nxt_v = 7'd12;
      drive_and_check();
      // Without the commit, allocation restarts right after the branch
      check_preg("inst_out_to_sch0.dest_preg", inst_out_to_sch0.dest_preg,
                 commit_first ? 6'd39 : 6'd33);
   endtask

   initial begin
      rst_n <= 1'b0;
      drive_idle();
      ret_v = '{default: '0};
      mp_idx = '0;
      cb_idx = '0;
      test_first_group();
      test_random_groups();
      test_hold();
      test_exhaust();
      test_branch_recovery(1'b0);
      test_branch_recovery(1'b1);
      $display("Value errors: %0d, other errors: %0d", val_errs, other_errs);
      if (val_errs == 0 && other_errs == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- alloc_stage.f
+incdir+include
source/alloc_inst_pkg.sv
source/alloc_rob_pkg.sv
source/inst_checker.sv
source/branch_unit.sv
source/free_list.sv
source/inst_combiner.sv
source/alloc_stage.sv
verif/alloc_stage_chk.sv
verif/alloc_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the alloc_stage testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module alloc_stage_tb -f alloc_stage.f -o alloc_stage_sim \
   || { echo "Build failed"; exit 1; }

sim_out="$(./obj_dir/alloc_stage_sim)"
echo "$sim_out"
echo "$sim_out" | grep -qF '*** PASSED ***' && exit 0 || exit 1
